/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert
TOP       := tb_team_01_cpu
FILELIST  := list.f

SRCS := $(filter-out +%,$(shell cat $(FILELIST)))
BIN  := obj_dir/V$(TOP)
LOG  := sim.log

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -q "All tests passed!" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* alu.sv */
// ALU with the RV32I integer operations and the branch condition check
`timescale 1ns/1ps

module alu (
  input  cpu_pkg::alu_op_e op_i,
  input  cpu_pkg::word_t   a_i,
  input  cpu_pkg::word_t   b_i,
  input  cpu_pkg::branch_e branch_i,
  output cpu_pkg::word_t   result_o,
  output logic             take_o
);

  logic [4:0] shamt;

  assign shamt = b_i[4:0];

  always_comb begin
    case (op_i)
      cpu_pkg::ALU_SUB:  result_o = a_i - b_i;
      cpu_pkg::ALU_AND:  result_o = a_i & b_i;
      cpu_pkg::ALU_OR:   result_o = a_i | b_i;
      cpu_pkg::ALU_XOR:  result_o = a_i ^ b_i;
      cpu_pkg::ALU_SLT:  result_o = {31'b0, $signed(a_i) < $signed(b_i)};
      cpu_pkg::ALU_SLTU: result_o = {31'b0, a_i < b_i};
      cpu_pkg::ALU_SLL:  result_o = a_i << shamt;
      cpu_pkg::ALU_SRL:  result_o = a_i >> shamt;
      cpu_pkg::ALU_SRA:  result_o = $signed(a_i) >>> shamt;
      default:           result_o = a_i + b_i;
    endcase
  end

  // Branch compare runs on the raw operands
  always_comb begin
    case (branch_i)
      cpu_pkg::BR_EQ:  take_o = (a_i == b_i);
      cpu_pkg::BR_NE:  take_o = (a_i != b_i);
      cpu_pkg::BR_LT:  take_o = ($signed(a_i) < $signed(b_i));
      cpu_pkg::BR_GE:  take_o = ($signed(a_i) >= $signed(b_i));
      cpu_pkg::BR_LTU: take_o = (a_i < b_i);
      cpu_pkg::BR_GEU: take_o = (a_i >= b_i);
      default:         take_o = 1'b0;
    endcase
  end

endmodule

/* core_req_if.sv */
// Core request interface between the instruction sequencer and the bus request unit
`timescale 1ns/1ps

interface core_req_if;

  // Requests from the sequencer, one pulse each
  logic                instr_req;
  cpu_pkg::word_t      instr_adr;
  logic                data_read;
  logic                data_write;
  cpu_pkg::word_t      data_adr;
  cpu_pkg::word_t      write_data;

  // Completions back from the request unit
  logic                ihit;
  cpu_pkg::word_t      fetched_instr;
  logic                dhit;
  cpu_pkg::word_t      fetched_data;

  modport core (
    output instr_req, instr_adr, data_read, data_write, data_adr, write_data,
    input  ihit, fetched_instr, dhit, fetched_data
  );

  modport unit (
    input  instr_req, instr_adr, data_read, data_write, data_adr, write_data,
    output ihit, fetched_instr, dhit, fetched_data
  );

endinterface

/* cpu_pkg.sv */
// CPU package with the shared word types, encodings and control struct of the RV32I core
package cpu_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_idx_t;

  // First fetch address after reset
  localparam word_t RESET_PC = 32'h0000_0000;

  // Word accesses only, so every byte lane is enabled
  localparam logic [3:0] FULL_SEL = 4'b1111;

  // Major opcodes of the supported subset
  typedef enum logic [6:0] {
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111,
    OPC_JAL    = 7'b1101111,
    OPC_JALR   = 7'b1100111,
    OPC_BRANCH = 7'b1100011,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_OP_IMM = 7'b0010011,
    OPC_OP     = 7'b0110011
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_SLTU,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA
  } alu_op_e;

  // Branch kind is funct3 itself, 010 is unused by RV32I and marks no branch
  typedef enum logic [2:0] {
    BR_EQ   = 3'b000,
    BR_NE   = 3'b001,
    BR_NONE = 3'b010,
    BR_LT   = 3'b100,
    BR_GE   = 3'b101,
    BR_LTU  = 3'b110,
    BR_GEU  = 3'b111
  } branch_e;

  typedef struct packed {
    alu_op_e alu_op;
    logic    alu_src_imm;
    logic    alu_src_pc;
    logic    reg_write;
    logic    mem_read;
    logic    mem_write;
    logic    mem_to_reg;
    logic    jump;
    logic    jalr;
    logic    lui;
    branch_e branch;
  } ctrl_t;

endpackage

/* decode_unit.sv */
// Decode unit that maps an RV32I instruction onto control signals and an immediate
`timescale 1ns/1ps

module decode_unit (
  input  cpu_pkg::word_t    instr_i,
  output cpu_pkg::ctrl_t    ctrl_o,
  output cpu_pkg::word_t    imm_o,
  output cpu_pkg::reg_idx_t rs1_o,
  output cpu_pkg::reg_idx_t rs2_o,
  output cpu_pkg::reg_idx_t rd_o
);

  logic [2:0]     funct3;
  cpu_pkg::word_t imm_i;
  cpu_pkg::word_t imm_s;
  cpu_pkg::word_t imm_b;
  cpu_pkg::word_t imm_u;
  cpu_pkg::word_t imm_j;

  // Register-register ops use bit 30 for SUB, immediate ops only for SRA
  function automatic cpu_pkg::alu_op_e alu_from_funct(input logic [2:0] f3,
                                                      input logic       b30,
                                                      input logic       reg_op);
    cpu_pkg::alu_op_e op;
    case (f3)
      3'b000:  op = (reg_op && b30) ? cpu_pkg::ALU_SUB : cpu_pkg::ALU_ADD;
      3'b001:  op = cpu_pkg::ALU_SLL;
      3'b010:  op = cpu_pkg::ALU_SLT;
      3'b011:  op = cpu_pkg::ALU_SLTU;
      3'b100:  op = cpu_pkg::ALU_XOR;
      3'b101:  op = b30 ? cpu_pkg::ALU_SRA : cpu_pkg::ALU_SRL;
      3'b110:  op = cpu_pkg::ALU_OR;
      default: op = cpu_pkg::ALU_AND;
    endcase
    return op;
  endfunction

  assign funct3 = instr_i[14:12];
  assign rs1_o  = instr_i[19:15];
  assign rs2_o  = instr_i[24:20];
  assign rd_o   = instr_i[11:7];

  assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  assign imm_b = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                  instr_i[11:8], 1'b0};
  assign imm_u = {instr_i[31:12], 12'b0};
  assign imm_j = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                  instr_i[30:21], 1'b0};

  always_comb begin
    // Default is a no-op with no writes
    ctrl_o        = '0;
    ctrl_o.alu_op = cpu_pkg::ALU_ADD;
    ctrl_o.branch = cpu_pkg::BR_NONE;
    imm_o         = '0;
    case (instr_i[6:0])
      cpu_pkg::OPC_LUI: begin
        ctrl_o.lui       = 1'b1;
        ctrl_o.reg_write = 1'b1;
        imm_o            = imm_u;
      end
      cpu_pkg::OPC_AUIPC: begin
        ctrl_o.alu_src_pc  = 1'b1;
        ctrl_o.alu_src_imm = 1'b1;
        ctrl_o.reg_write   = 1'b1;
        imm_o              = imm_u;
      end
      cpu_pkg::OPC_JAL: begin
        ctrl_o.jump      = 1'b1;
        ctrl_o.reg_write = 1'b1;
        imm_o            = imm_j;
      end
      cpu_pkg::OPC_JALR: begin
        ctrl_o.jalr        = 1'b1;
        ctrl_o.alu_src_imm = 1'b1;
        ctrl_o.reg_write   = 1'b1;
        imm_o              = imm_i;
      end
      cpu_pkg::OPC_BRANCH: begin
        imm_o = imm_b;
        // 010 and 011 are not branches and stay a no-op
        if (funct3 != 3'b010 && funct3 != 3'b011) begin
          ctrl_o.branch = cpu_pkg::branch_e'(funct3);
        end
      end
      cpu_pkg::OPC_LOAD: begin
        imm_o = imm_i;
        if (funct3 == 3'b010) begin
          ctrl_o.alu_src_imm = 1'b1;
          ctrl_o.mem_read    = 1'b1;
          ctrl_o.mem_to_reg  = 1'b1;
          ctrl_o.reg_write   = 1'b1;
        end
      end
      cpu_pkg::OPC_STORE: begin
        imm_o = imm_s;
        if (funct3 == 3'b010) begin
          ctrl_o.alu_src_imm = 1'b1;
          ctrl_o.mem_write   = 1'b1;
        end
      end
      cpu_pkg::OPC_OP_IMM: begin
        ctrl_o.alu_op      = alu_from_funct(funct3, instr_i[30], 1'b0);
        ctrl_o.alu_src_imm = 1'b1;
        ctrl_o.reg_write   = 1'b1;
        imm_o              = imm_i;
      end
      cpu_pkg::OPC_OP: begin
        ctrl_o.alu_op    = alu_from_funct(funct3, instr_i[30], 1'b1);
        ctrl_o.reg_write = 1'b1;
      end
      default: begin
        ctrl_o.reg_write = 1'b0;
      end
    endcase
  end

endmodule

/* list.f */
cpu_pkg.sv
core_req_if.sv
request_unit.sv
decode_unit.sv
register_file.sv
alu.sv
team_01_cpu.sv
tb_bus_memory.sv
tb_team_01_cpu.sv

/* register_file.sv */
// Register file with 32 words, two read ports, one write port and x0 tied to zero
`timescale 1ns/1ps

module register_file (
  input  logic              clk,
  input  logic              arst_n_i,
  input  logic              we_i,
  input  cpu_pkg::reg_idx_t rs1_i,
  input  cpu_pkg::reg_idx_t rs2_i,
  input  cpu_pkg::reg_idx_t rd_i,
  input  cpu_pkg::word_t    wd_i,
  output cpu_pkg::word_t    rd1_o,
  output cpu_pkg::word_t    rd2_o
);

  cpu_pkg::word_t regs [32];

  // x0 is cleared by reset and never written
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i && rd_i != '0) begin
      regs[rd_i] <= wd_i;
    end
  end

  assign rd1_o = regs[rs1_i];
  assign rd2_o = regs[rs2_i];

  a_x0_zero : assert property (@(posedge clk) disable iff (!arst_n_i)
    (rs1_i == '0) |-> (rd1_o == '0));

endmodule

/* request_unit.sv */
// Request unit that turns fetch and data requests into single bus transactions
`timescale 1ns/1ps

module request_unit (
  input  logic                 clk,
  input  logic                 arst_n_i,
  core_req_if.unit             req,
  input  logic                 busy_i,
  input  cpu_pkg::word_t       bus_dat_i,
  output cpu_pkg::word_t       bus_adr_o,
  output cpu_pkg::word_t       bus_dat_o,
  output logic [3:0]           bus_sel_o,
  output logic                 bus_read_o,
  output logic                 bus_write_o
);

  logic           new_req;
  logic           done;
  logic           rd_q;
  logic           wr_q;
  logic           active_q;
  logic           instr_q;
  logic           busy_seen_q;
  logic           ihit_q;
  logic           dhit_q;
  cpu_pkg::word_t adr_q;
  cpu_pkg::word_t wdat_q;
  cpu_pkg::word_t rdat_q;

  assign new_req = req.instr_req | req.data_read | req.data_write;

  // Busy has gone high and dropped again
  assign done = active_q & busy_seen_q & ~busy_i;

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rd_q        <= 1'b0;
      wr_q        <= 1'b0;
      active_q    <= 1'b0;
      instr_q     <= 1'b0;
      busy_seen_q <= 1'b0;
      ihit_q      <= 1'b0;
      dhit_q      <= 1'b0;
    end else begin
      // Strobes last exactly one cycle
      rd_q   <= req.instr_req | req.data_read;
      wr_q   <= req.data_write;
      ihit_q <= done & instr_q;
      dhit_q <= done & ~instr_q;
      if (new_req) begin
        active_q    <= 1'b1;
        instr_q     <= req.instr_req;
        busy_seen_q <= 1'b0;
      end else if (done) begin
        active_q    <= 1'b0;
        busy_seen_q <= 1'b0;
      end else if (active_q && busy_i) begin
        busy_seen_q <= 1'b1;
      end
    end
  end

  // Address and write data held until the transaction ends
  always_ff @(posedge clk) begin
    if (new_req) begin
      adr_q  <= req.instr_req ? req.instr_adr : req.data_adr;
      wdat_q <= req.write_data;
    end
    if (done) begin
      rdat_q <= bus_dat_i;
    end
  end

  assign bus_read_o        = rd_q;
  assign bus_write_o       = wr_q;
  assign bus_adr_o         = adr_q;
  assign bus_dat_o         = wdat_q;
  assign bus_sel_o         = cpu_pkg::FULL_SEL;
  assign req.ihit          = ihit_q;
  assign req.dhit          = dhit_q;
  assign req.fetched_instr = rdat_q;
  assign req.fetched_data  = rdat_q;

  a_one_strobe : assert property (@(posedge clk) disable iff (!arst_n_i)
    !(bus_read_o && bus_write_o));

  // The sequencer waits for the hit before asking again
  a_no_overlap : assert property (@(posedge clk) disable iff (!arst_n_i)
    new_req |-> !active_q);

endmodule

/* tb_bus_memory.sv */
// Testbench bus slave with a word memory, random busy lengths and a transaction record output
`timescale 1ns/1ps

module tb_bus_memory (
  input  logic           clk,
  input  logic           arst_n_i,
  input  logic           bus_read_i,
  input  logic           bus_write_i,
  input  cpu_pkg::word_t bus_adr_i,
  input  cpu_pkg::word_t bus_dat_i,
  output logic           busy_o,
  output cpu_pkg::word_t bus_dat_o,
  output logic           rec_valid_o,
  output logic           rec_write_o,
  output cpu_pkg::word_t rec_adr_o,
  output cpu_pkg::word_t rec_dat_o,
  output logic           overlap_o
);

  cpu_pkg::word_t mem [4096];
  integer         seed = 32'h47c74132;
  logic           pending;
  logic           p_wr;
  cpu_pkg::word_t p_adr;
  cpu_pkg::word_t p_dat;
  int             count;

  initial begin
    busy_o      = 1'b0;
    bus_dat_o   = '0;
    rec_valid_o = 1'b0;
    rec_write_o = 1'b0;
    rec_adr_o   = '0;
    rec_dat_o   = '0;
    overlap_o   = 1'b0;
    pending     = 1'b0;
    count       = 0;
  end

  // Sample the strobes at the edge, answer shortly after it
  always @(posedge clk) begin
    logic           rd;
    logic           wr;
    cpu_pkg::word_t adr;
    cpu_pkg::word_t dat;
    rd  = bus_read_i;
    wr  = bus_write_i;
    adr = bus_adr_i;
    dat = bus_dat_i;
    #2;
    rec_valid_o = 1'b0;
    if (!arst_n_i) begin
      busy_o    = 1'b0;
      pending   = 1'b0;
      overlap_o = 1'b0;
    end else if (rd || wr) begin
      // A strobe during a pending access means a repeat or an overlap
      if (pending) begin
        overlap_o = 1'b1;
      end
      pending = 1'b1;
      p_wr    = wr;
      p_adr   = adr;
      p_dat   = dat;
      busy_o  = 1'b1;
      count   = 1 + int'($unsigned($random(seed)) % 6);
    end else if (pending) begin
      count = count - 1;
      if (count == 0) begin
        busy_o  = 1'b0;
        pending = 1'b0;
        if (p_wr) begin
          mem[p_adr[13:2]] = p_dat;
        end else begin
          bus_dat_o = mem[p_adr[13:2]];
        end
        rec_valid_o = 1'b1;
        rec_write_o = p_wr;
        rec_adr_o   = p_adr;
        rec_dat_o   = p_wr ? p_dat : mem[p_adr[13:2]];
      end
    end
  end

endmodule

/* tb_team_01_cpu.sv */
// Testbench top with random RV32I programs, an architectural model and bus transaction checks
`timescale 1ns/1ps

module tb_team_01_cpu;

  localparam int PROG_LEN = 48;

  logic           clk = 1'b0;
  logic           arst_n;
  logic           pc_enable;
  logic           busy;
  cpu_pkg::word_t rdata;
  cpu_pkg::word_t wdata;
  cpu_pkg::word_t adr;
  logic [3:0]     sel;
  logic           bus_rd;
  logic           bus_wr;
  logic           rec_valid;
  logic           rec_write;
  cpu_pkg::word_t rec_adr;
  cpu_pkg::word_t rec_dat;
  logic           overlap;

  integer         seed = 32'h47c74132;
  int             errors;
  int             checks;
  int             n;
  bit             checking;
  cpu_pkg::word_t model_mem [4096];
  int             exp_kind [$];
  cpu_pkg::word_t exp_adr [$];
  cpu_pkg::word_t exp_dat [$];

  team_01_cpu team_01_cpu_i (
    .clk         (clk),
    .arst_n_i    (arst_n),
    .pc_enable_i (pc_enable),
    .busy_i      (busy),
    .bus_dat_i   (rdata),
    .bus_dat_o   (wdata),
    .bus_adr_o   (adr),
    .bus_sel_o   (sel),
    .bus_write_o (bus_wr),
    .bus_read_o  (bus_rd)
  );

  tb_bus_memory memory_i (
    .clk         (clk),
    .arst_n_i    (arst_n),
    .bus_read_i  (bus_rd),
    .bus_write_i (bus_wr),
    .bus_adr_i   (adr),
    .bus_dat_i   (wdata),
    .busy_o      (busy),
    .bus_dat_o   (rdata),
    .rec_valid_o (rec_valid),
    .rec_write_o (rec_write),
    .rec_adr_o   (rec_adr),
    .rec_dat_o   (rec_dat),
    .overlap_o   (overlap)
  );

  always #10 clk = ~clk;

  function automatic int rnd(input int lim);
    return int'($unsigned($random(seed)) % lim);
  endfunction

  function automatic cpu_pkg::reg_idx_t rand_reg();
    return cpu_pkg::reg_idx_t'(1 + rnd(30));
  endfunction

  function automatic cpu_pkg::reg_idx_t any_reg();
    return cpu_pkg::reg_idx_t'(rnd(32));
  endfunction

  function automatic cpu_pkg::word_t fill_word(input int idx);
    return 32'h6b00_0000 ^ (32'(idx) * 32'h0001_0003);
  endfunction

  // Instruction encoders
  function automatic cpu_pkg::word_t enc_i(input logic [11:0] imm, input cpu_pkg::reg_idx_t rs1,
                                           input logic [2:0] f3, input cpu_pkg::reg_idx_t rd,
                                           input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic cpu_pkg::word_t enc_r(input logic [6:0] f7, input cpu_pkg::reg_idx_t rs2,
                                           input cpu_pkg::reg_idx_t rs1, input logic [2:0] f3,
                                           input cpu_pkg::reg_idx_t rd);
    return {f7, rs2, rs1, f3, rd, cpu_pkg::OPC_OP};
  endfunction

  function automatic cpu_pkg::word_t enc_s(input logic [11:0] imm, input cpu_pkg::reg_idx_t rs2);
    return {imm[11:5], rs2, 5'd31, 3'b010, imm[4:0], cpu_pkg::OPC_STORE};
  endfunction

  function automatic cpu_pkg::word_t enc_b(input logic [12:0] off, input cpu_pkg::reg_idx_t rs2,
                                           input cpu_pkg::reg_idx_t rs1, input logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], cpu_pkg::OPC_BRANCH};
  endfunction

  function automatic cpu_pkg::word_t enc_u(input logic [19:0] imm, input cpu_pkg::reg_idx_t rd,
                                           input logic [6:0] op);
    return {imm, rd, op};
  endfunction

  function automatic cpu_pkg::word_t enc_j(input logic [20:0] off, input cpu_pkg::reg_idx_t rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, cpu_pkg::OPC_JAL};
  endfunction

  task automatic put(input cpu_pkg::word_t w);
    memory_i.mem[12'(n)] = w;
    model_mem[12'(n)]    = w;
    n++;
  endtask

  // Byte offset to a later instruction inside the program
  function automatic int fwd_off();
    return (1 + rnd(PROG_LEN - 1 - n)) * 4;
  endfunction

  task automatic gen_alu(output cpu_pkg::reg_idx_t rd);
    logic [2:0]  f3;
    logic        alt;
    logic [11:0] imm;
    rd  = rand_reg();
    f3  = 3'(rnd(8));
    alt = 1'(rnd(2));
    imm = 12'(rnd(4096));
    if (rnd(3) == 0) begin
      put(enc_u(20'($random(seed)), rd, rnd(2) ? cpu_pkg::OPC_LUI : cpu_pkg::OPC_AUIPC));
    end else if (rnd(2) == 0) begin
      if (f3 == 3'd1) begin
        imm = {7'b0, imm[4:0]};
      end else if (f3 == 3'd5) begin
        imm = {1'b0, alt, 5'b0, imm[4:0]};
      end
      put(enc_i(imm, any_reg(), f3, rd, cpu_pkg::OPC_OP_IMM));
    end else begin
      put(enc_r({1'b0, alt && (f3 == 3'd0 || f3 == 3'd5), 5'b0}, any_reg(), any_reg(), f3, rd));
    end
  endtask

  task automatic gen_flow(output cpu_pkg::reg_idx_t rd);
    int                br [6] = '{0, 1, 4, 5, 6, 7};
    cpu_pkg::reg_idx_t rs1;
    int                pick;
    rd   = rand_reg();
    rs1  = any_reg();
    pick = rnd(3);
    if (pick == 0) begin
      rd = '0;
      put(enc_b(13'(fwd_off()), rnd(4) == 0 ? rs1 : any_reg(), rs1, 3'(br[rnd(6)])));
    end else if (pick == 1) begin
      put(enc_j(21'(fwd_off()), rd));
    end else begin
      // Absolute target from x0 with bit 0 set now and then
      put(enc_i(12'(n * 4 + fwd_off() + rnd(2)), 5'd0, 3'b000, rd, cpu_pkg::OPC_JALR));
    end
  endtask

  // Program kind 0 is an idle loop, 2 arithmetic, 3 memory, 4 control flow and 5 mixed
  task automatic build_program(input int kind);
    cpu_pkg::reg_idx_t rd;
    int                off;
    int                pick;
    for (int i = 0; i < 4096; i++) begin
      memory_i.mem[i] = fill_word(i);
      model_mem[i]    = fill_word(i);
    end
    n = 0;
    put(enc_u(20'd2, 5'd31, cpu_pkg::OPC_LUI));
    while (kind != 0 && n < PROG_LEN - 4) begin
      pick = (kind == 5) ? rnd(3) : kind - 2;
      if (pick == 0) begin
        gen_alu(rd);
      end else if (pick == 1) begin
        off = rnd(64) * 4;
        put(enc_s(12'(off), any_reg()));
        rd = rand_reg();
        put(enc_i(12'(off), 5'd31, 3'b010, rd, cpu_pkg::OPC_LOAD));
      end else begin
        gen_flow(rd);
      end
      put(enc_s(12'(rnd(64) * 4), rd));
    end
    // FENCE encoding lies outside the subset
    while (n < PROG_LEN - 1) begin
      put(32'h0000_000f);
    end
    put(enc_j(21'd0, 5'd0));
  endtask

  function automatic cpu_pkg::word_t alu_ref(input logic [2:0] f3, input logic alt,
                                             input cpu_pkg::word_t a, input cpu_pkg::word_t b);
    case (f3)
      3'd0: return alt ? a - b : a + b;
      3'd1: return a << b[4:0];
      3'd2: return {31'b0, $signed(a) < $signed(b)};
      3'd3: return {31'b0, a < b};
      3'd4: return a ^ b;
      3'd5: begin
        if (alt) begin
          return $signed(a) >>> b[4:0];
        end
        return a >> b[4:0];
      end
      3'd6: return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic bit taken(input logic [2:0] f3, input cpu_pkg::word_t a,
                               input cpu_pkg::word_t b);
    case (f3)
      3'd0: return a == b;
      3'd1: return a != b;
      3'd4: return $signed(a) < $signed(b);
      3'd5: return $signed(a) >= $signed(b);
      3'd6: return a < b;
      3'd7: return a >= b;
      default: return 1'b0;
    endcase
  endfunction

  // Architectural run that fills the expected bus transaction queues
  task automatic run_model();
    cpu_pkg::word_t x [32];
    cpu_pkg::word_t pc;
    cpu_pkg::word_t ins;
    cpu_pkg::word_t a;
    cpu_pkg::word_t b;
    cpu_pkg::word_t imm_i;
    cpu_pkg::word_t val;
    cpu_pkg::word_t addr;
    cpu_pkg::word_t npc;
    bit             wb;
    for (int i = 0; i < 32; i++) begin
      x[i] = '0;
    end
    exp_kind.delete();
    exp_adr.delete();
    exp_dat.delete();
    pc = cpu_pkg::RESET_PC;
    for (int step = 0; step < 2000; step++) begin
      exp_kind.push_back(0);
      exp_adr.push_back(pc);
      exp_dat.push_back('0);
      if (pc == 32'(4 * (PROG_LEN - 1))) begin
        break;
      end
      ins   = model_mem[pc[13:2]];
      a     = x[ins[19:15]];
      b     = x[ins[24:20]];
      imm_i = {{20{ins[31]}}, ins[31:20]};
      npc   = pc + 32'd4;
      wb    = 1'b0;
      val   = '0;
      case (ins[6:0])
        cpu_pkg::OPC_LUI: begin
          wb  = 1'b1;
          val = {ins[31:12], 12'b0};
        end
        cpu_pkg::OPC_AUIPC: begin
          wb  = 1'b1;
          val = pc + {ins[31:12], 12'b0};
        end
        cpu_pkg::OPC_JAL: begin
          wb  = 1'b1;
          val = pc + 32'd4;
          npc = pc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
        end
        cpu_pkg::OPC_JALR: begin
          wb  = 1'b1;
          val = pc + 32'd4;
          npc = (a + imm_i) & ~32'd1;
        end
        cpu_pkg::OPC_BRANCH: begin
          if (taken(ins[14:12], a, b)) begin
            npc = pc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
          end
        end
        cpu_pkg::OPC_LOAD: begin
          if (ins[14:12] == 3'b010) begin
            addr = a + imm_i;
            wb   = 1'b1;
            val  = model_mem[addr[13:2]];
            exp_kind.push_back(1);
            exp_adr.push_back(addr);
            exp_dat.push_back('0);
          end
        end
        cpu_pkg::OPC_STORE: begin
          if (ins[14:12] == 3'b010) begin
            addr = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
            model_mem[addr[13:2]] = b;
            exp_kind.push_back(2);
            exp_adr.push_back(addr);
            exp_dat.push_back(b);
          end
        end
        cpu_pkg::OPC_OP_IMM: begin
          wb  = 1'b1;
          val = alu_ref(ins[14:12], ins[30] && ins[14:12] == 3'd5, a, imm_i);
        end
        cpu_pkg::OPC_OP: begin
          wb  = 1'b1;
          val = alu_ref(ins[14:12], ins[30], a, b);
        end
        default: wb = 1'b0;
      endcase
      if (wb && ins[11:7] != 5'd0) begin
        x[ins[11:7]] = val;
      end
      pc = npc;
    end
  endtask

  task automatic check_fetch(input cpu_pkg::word_t exp_a, input cpu_pkg::word_t got_a);
    if (got_a !== exp_a) begin
      $display("Mismatch at %0t: fetch from %h, expected %h", $time, got_a, exp_a);
      errors++;
    end
  endtask

  task automatic check_load(input cpu_pkg::word_t exp_a, input cpu_pkg::word_t got_a);
    if (got_a !== exp_a) begin
      $display("Mismatch at %0t: load from %h, expected %h", $time, got_a, exp_a);
      errors++;
    end
  endtask

  task automatic check_store(input cpu_pkg::word_t exp_a, input cpu_pkg::word_t exp_d,
                             input cpu_pkg::word_t got_a, input cpu_pkg::word_t got_d);
    if (got_a !== exp_a || got_d !== exp_d) begin
      $display("Mismatch at %0t: store %h to %h, expected %h to %h",
               $time, got_d, got_a, exp_d, exp_a);
      errors++;
    end
  endtask

  task automatic check_sel(input logic [3:0] exp_s, input logic [3:0] got_s);
    if (got_s !== exp_s) begin
      $display("Mismatch at %0t: byte select %b, expected %b", $time, got_s, exp_s);
      errors++;
    end
  endtask

  task automatic check_idle(input int cycles, input string why);
    for (int i = 0; i < cycles; i++) begin
      @(posedge clk);
      if (bus_rd || bus_wr) begin
        $display("Bus strobe at %0t while %s", $time, why);
        errors++;
      end
    end
  endtask

  // Compare each completed bus transaction with the next expected one
  always @(posedge clk) begin
    int             kind;
    cpu_pkg::word_t ea;
    cpu_pkg::word_t ed;
    if (checking && rec_valid && exp_kind.size() > 0) begin
      kind = exp_kind.pop_front();
      ea   = exp_adr.pop_front();
      ed   = exp_dat.pop_front();
      checks++;
      if (rec_write != (kind == 2)) begin
        $display("Mismatch at %0t: bus %s at %h, expected kind %0d at %h",
                 $time, rec_write ? "write" : "read", rec_adr, kind, ea);
        errors++;
      end else if (kind == 0) begin
        check_fetch(ea, rec_adr);
      end else if (kind == 1) begin
        check_load(ea, rec_adr);
      end else begin
        check_store(ea, ed, rec_adr, rec_dat);
      end
    end
    // Word accesses enable all four byte lanes
    if (checking && (bus_rd || bus_wr)) begin
      check_sel(4'b1111, sel);
    end
  end

  task automatic reset_core();
    @(posedge clk);
    #2 arst_n = 1'b0;
    check_idle(16, "arst_n_i is low");
    #2 arst_n = 1'b1;
  endtask

  task automatic gate_runs();
    for (int g = 0; g < 4 && exp_kind.size() > 4; g++) begin
      repeat (5 + rnd(30)) @(posedge clk);
      #2 pc_enable = 1'b0;
      // Let the instruction in flight retire
      repeat (30) @(posedge clk);
      check_idle(20, "pc_enable_i is low");
      #2 pc_enable = 1'b1;
    end
  endtask

  task automatic run_test(input int num, input string name, input int kind, input bit gate);
    int mark;
    int cycles;
    mark = errors;
    build_program(kind);
    run_model();
    reset_core();
    checking = 1'b1;
    fork
      begin
        cycles = 0;
        while (exp_kind.size() > 0 && cycles < 20000) begin
          @(posedge clk);
          cycles++;
        end
        if (exp_kind.size() > 0) begin
          $display("Timeout: %0d bus transactions never arrived", exp_kind.size());
          errors++;
        end
      end
      begin
        if (gate) begin
          gate_runs();
        end
      end
    join
    checking = 1'b0;
    if (overlap) begin
      $display("A bus strobe arrived before the previous transaction completed");
      errors++;
    end
    $display("Test %0d %s finished with %0d errors", num, name, errors - mark);
  endtask

  initial begin
    arst_n    = 1'b0;
    pc_enable = 1'b1;
    checking  = 1'b0;
    errors    = 0;
    checks    = 0;
    run_test(1, "reset", 0, 1'b0);
    run_test(2, "arithmetic", 2, 1'b0);
    run_test(3, "memory", 3, 1'b0);
    run_test(4, "control flow", 4, 1'b0);
    run_test(5, "back-pressure", 5, 1'b0);
    run_test(6, "run gating", 5, 1'b1);
    $display("Tests: 6, bus checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

/* team_01_cpu.sv */
// Multicycle RV32I core top with PC, instruction register and phase sequencer
`timescale 1ns/1ps

module team_01_cpu (
  input  logic           clk,
  input  logic           arst_n_i,
  input  logic           pc_enable_i,
  input  logic           busy_i,
  input  cpu_pkg::word_t bus_dat_i,
  output cpu_pkg::word_t bus_dat_o,
  output cpu_pkg::word_t bus_adr_o,
  output logic [3:0]     bus_sel_o,
  output logic           bus_write_o,
  output logic           bus_read_o
);

  typedef enum logic [1:0] {FETCH, WAIT_I, EXEC, WAIT_D} phase_e;

  phase_e            phase_q;
  cpu_pkg::word_t    pc_q;
  cpu_pkg::word_t    ir_q;
  cpu_pkg::word_t    pc_plus4;
  cpu_pkg::word_t    next_pc;
  cpu_pkg::ctrl_t    ctrl;
  cpu_pkg::word_t    imm;
  cpu_pkg::reg_idx_t rs1;
  cpu_pkg::reg_idx_t rs2;
  cpu_pkg::reg_idx_t rd;
  cpu_pkg::word_t    rd1;
  cpu_pkg::word_t    rd2;
  cpu_pkg::word_t    alu_a;
  cpu_pkg::word_t    alu_b;
  cpu_pkg::word_t    alu_result;
  cpu_pkg::word_t    wb_data;
  logic              take;
  logic              mem_op;
  logic              exec_cycle;
  logic              rf_we;

  core_req_if req_if ();

  request_unit request_unit_i (
    .clk         (clk),
    .arst_n_i    (arst_n_i),
    .req         (req_if.unit),
    .busy_i      (busy_i),
    .bus_dat_i   (bus_dat_i),
    .bus_adr_o   (bus_adr_o),
    .bus_dat_o   (bus_dat_o),
    .bus_sel_o   (bus_sel_o),
    .bus_read_o  (bus_read_o),
    .bus_write_o (bus_write_o)
  );

  decode_unit decode_unit_i (
    .instr_i (ir_q),
    .ctrl_o  (ctrl),
    .imm_o   (imm),
    .rs1_o   (rs1),
    .rs2_o   (rs2),
    .rd_o    (rd)
  );

  register_file register_file_i (
    .clk      (clk),
    .arst_n_i (arst_n_i),
    .we_i     (rf_we),
    .rs1_i    (rs1),
    .rs2_i    (rs2),
    .rd_i     (rd),
    .wd_i     (wb_data),
    .rd1_o    (rd1),
    .rd2_o    (rd2)
  );

  alu alu_i (
    .op_i     (ctrl.alu_op),
    .a_i      (alu_a),
    .b_i      (alu_b),
    .branch_i (ctrl.branch),
    .result_o (alu_result),
    .take_o   (take)
  );

  assign exec_cycle = (phase_q == EXEC);
  assign mem_op     = ctrl.mem_read | ctrl.mem_write;
  assign alu_a      = ctrl.alu_src_pc ? pc_q : rd1;
  assign alu_b      = ctrl.alu_src_imm ? imm : rd2;
  assign pc_plus4   = pc_q + 32'd4;

  // Write-back select, links take priority over the ALU
  always_comb begin
    if (ctrl.mem_to_reg) begin
      wb_data = req_if.fetched_data;
    end else if (ctrl.jump || ctrl.jalr) begin
      wb_data = pc_plus4;
    end else if (ctrl.lui) begin
      wb_data = imm;
    end else begin
      wb_data = alu_result;
    end
  end

  always_comb begin
    if (ctrl.jalr) begin
      next_pc = alu_result & ~32'd1;
    end else if (ctrl.jump || take) begin
      next_pc = pc_q + imm;
    end else begin
      next_pc = pc_plus4;
    end
  end

  // Loads write on dhit, everything else at the end of EXEC
  assign rf_we = ctrl.reg_write &
                 ((exec_cycle & ~mem_op) | ((phase_q == WAIT_D) & req_if.dhit));

  assign req_if.instr_req  = (phase_q == FETCH) & pc_enable_i;
  assign req_if.instr_adr  = pc_q;
  assign req_if.data_read  = exec_cycle & ctrl.mem_read;
  assign req_if.data_write = exec_cycle & ctrl.mem_write;
  assign req_if.data_adr   = alu_result;
  assign req_if.write_data = rd2;

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      phase_q <= FETCH;
      pc_q    <= cpu_pkg::RESET_PC;
    end else begin
      case (phase_q)
        FETCH: begin
          if (pc_enable_i) begin
            phase_q <= WAIT_I;
          end
        end
        WAIT_I: begin
          if (req_if.ihit) begin
            phase_q <= EXEC;
          end
        end
        EXEC: begin
          if (mem_op) begin
            phase_q <= WAIT_D;
          end else begin
            pc_q    <= next_pc;
            phase_q <= FETCH;
          end
        end
        default: begin
          if (req_if.dhit) begin
            pc_q    <= pc_plus4;
            phase_q <= FETCH;
          end
        end
      endcase
    end
  end

  // Instruction register
  always_ff @(posedge clk) begin
    if (phase_q == WAIT_I && req_if.ihit) begin
      ir_q <= req_if.fetched_instr;
    end
  end

endmodule
